// File: design/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic [31:0]    instr,
    output rvIsaPkg::ctrlT ctrl
);

    rvIsaPkg::opcodeT opcode;
    logic [6:0]       funct7;
    logic [2:0]       funct3;
    logic             unsupported;

    assign opcode = rvIsaPkg::opcodeT'(instr[6:0]);
    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];

    always_comb begin
        ctrl           = '0;
        ctrl.aluOp     = rvIsaPkg::ALU_ADD;  // Address and immediate arithmetic
        ctrl.resultSel = rvIsaPkg::RES_ALU;
        unsupported    = 1'b0;

        case (opcode)
            rvIsaPkg::R_TYPE: begin
                ctrl.regWrite = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.aluOp = rvIsaPkg::ALU_ADD;
                    10'b0100000_000: ctrl.aluOp = rvIsaPkg::ALU_SUB;
                    10'b0000000_111: ctrl.aluOp = rvIsaPkg::ALU_AND;
                    10'b0000000_110: ctrl.aluOp = rvIsaPkg::ALU_OR;
                    10'b0000000_010: ctrl.aluOp = rvIsaPkg::ALU_SLT;
                    default:         unsupported = 1'b1;
                endcase
            end
            rvIsaPkg::I_ALU: begin  // addi only
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                unsupported   = (funct3 != 3'b000);
            end
            rvIsaPkg::LOAD: begin  // lw only
                ctrl.aluSrc    = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.resultSel = rvIsaPkg::RES_MEM;
                unsupported    = (funct3 != 3'b010);
            end
            rvIsaPkg::STORE: begin  // sw only
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                unsupported   = (funct3 != 3'b010);
            end
            rvIsaPkg::BRANCH: begin  // beq compares by subtraction
                ctrl.branch = 1'b1;
                ctrl.aluOp  = rvIsaPkg::ALU_SUB;
                unsupported = (funct3 != 3'b000);
            end
            rvIsaPkg::LUI: begin
                ctrl.aluSrc    = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.resultSel = rvIsaPkg::RES_IMM;
            end
            rvIsaPkg::AUIPC: begin
                ctrl.aluSrc     = 1'b1;
                ctrl.pcRelative = 1'b1;
                ctrl.regWrite   = 1'b1;
            end
            rvIsaPkg::JAL: begin
                ctrl.aluSrc    = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.resultSel = rvIsaPkg::RES_PC4;  // Link address
            end
            rvIsaPkg::SYSTEM: ctrl.halt = 1'b1;  // ecall stops the program
            default:          unsupported = 1'b1;
        endcase

        // Unknown words halt with no side effects
        if (unsupported) begin
            ctrl         = '0;
            ctrl.aluOp   = rvIsaPkg::ALU_ADD;
            ctrl.halt    = 1'b1;
            ctrl.illegal = 1'b1;
        end

        assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("controlUnit: load and store decoded together");
    end

endmodule

// File: design/executeCore.sv
`timescale 1ns/1ps
`include "rvConfig_config.svh"

module executeCore (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   runEnable,
    input  hostBusPkg::hostAccessT hostAccess,
    output logic [31:0]            hostRdata,
    output logic                   retire,
    output logic                   haltEvent,
    output logic                   illegalEvent
);

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);
    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);
    localparam int REG_AW  = $clog2(`RV_REG_COUNT);

    logic [31:0] imem [`RV_IMEM_WORDS];
    logic [31:0] dmem [`RV_DMEM_WORDS];
    logic [31:0] regs [`RV_REG_COUNT];

    rvIsaPkg::ctrlT   ctrl;
    rvIsaPkg::opcodeT opcode;

    logic [31:0]        pc;
    logic [31:0]        instr;
    logic [REG_AW-1:0]  rs1;
    logic [REG_AW-1:0]  rs2;
    logic [REG_AW-1:0]  rd;
    logic [31:0]        rs1Data;
    logic [31:0]        rs2Data;
    logic [31:0]        imm;
    logic [31:0]        aluA;
    logic [31:0]        aluB;
    logic [31:0]        aluResult;
    logic [DMEM_AW-1:0] dIdx;
    logic [31:0]        loadData;
    logic [31:0]        regResult;
    logic [31:0]        wbData;
    logic [31:0]        pcPlus4;
    logic [31:0]        nextPc;
    logic               hostServe;
    logic               hostWrite;

    assign instr  = imem[pc[IMEM_AW+1:2]];
    assign opcode = rvIsaPkg::opcodeT'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    controlUnit controlUnit_i (
        .instr(instr),
        .ctrl (ctrl)
    );

    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    always_comb begin
        case (opcode)
            rvIsaPkg::STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvIsaPkg::BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                     instr[11:8], 1'b0};
            rvIsaPkg::LUI,
            rvIsaPkg::AUIPC:  imm = {instr[31:12], 12'b0};
            rvIsaPkg::JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                     instr[30:21], 1'b0};
            default:          imm = {{20{instr[31]}}, instr[31:20]};  // I-type
        endcase
    end

    assign aluA = ctrl.pcRelative ? pc : rs1Data;
    assign aluB = ctrl.aluSrc ? imm : rs2Data;

    always_comb begin
        case (ctrl.aluOp)
            rvIsaPkg::ALU_AND: aluResult = aluA & aluB;
            rvIsaPkg::ALU_OR:  aluResult = aluA | aluB;
            rvIsaPkg::ALU_ADD: aluResult = aluA + aluB;
            rvIsaPkg::ALU_SUB: aluResult = aluA - aluB;
            rvIsaPkg::ALU_SLT: aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
            default:           aluResult = '0;
        endcase
    end

    assign dIdx     = aluResult[DMEM_AW+1:2];
    assign loadData = ctrl.memRead ? dmem[dIdx] : '0;

    always_comb begin
        case (ctrl.resultSel)
            rvIsaPkg::RES_IMM: regResult = imm;
            rvIsaPkg::RES_PC4: regResult = pcPlus4;
            default:           regResult = aluResult;
        endcase
        wbData = ctrl.memToReg ? loadData : regResult;  // Loads override
    end

    // Taken beq sees a zero difference
    assign pcPlus4 = pc + 32'd4;
    assign nextPc  = ((ctrl.branch && aluResult == '0) || ctrl.jump) ? pc + imm : pcPlus4;

    assign retire       = runEnable && !ctrl.halt;
    assign haltEvent    = runEnable && ctrl.halt;
    assign illegalEvent = runEnable && ctrl.illegal;

    assign hostServe = hostAccess.valid && !runEnable;
    assign hostWrite = hostServe && hostAccess.write;

    always_ff @(posedge clk) begin
        if (reset || !runEnable) begin
            pc <= '0;  // Every run starts at address 0
        end else begin
            pc <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (hostWrite && hostAccess.sel == hostBusPkg::SEL_IMEM) begin
            imem[hostAccess.index[IMEM_AW-1:0]] <= hostAccess.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (runEnable && ctrl.memWrite) begin
            dmem[dIdx] <= rs2Data;
        end else if (hostWrite && hostAccess.sel == hostBusPkg::SEL_DMEM) begin
            dmem[hostAccess.index[DMEM_AW-1:0]] <= hostAccess.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (runEnable && ctrl.regWrite && rd != '0) begin
            regs[rd] <= wbData;
        end else if (hostWrite && hostAccess.sel == hostBusPkg::SEL_REG
                     && hostAccess.index[REG_AW-1:0] != '0) begin
            regs[hostAccess.index[REG_AW-1:0]] <= hostAccess.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (hostServe && !hostAccess.write) begin
            case (hostAccess.sel)
                hostBusPkg::SEL_IMEM: hostRdata <= imem[hostAccess.index[IMEM_AW-1:0]];
                hostBusPkg::SEL_DMEM: hostRdata <= dmem[hostAccess.index[DMEM_AW-1:0]];
                default:              hostRdata <= regs[hostAccess.index[REG_AW-1:0]];
            endcase
        end
    end

    // Neither the program nor the host may disturb x0
    x0AlwaysZero: assert property (@(posedge clk) disable iff (reset) regs[0] == 32'd0);

endmodule

// File: design/hostBusPkg.sv
`include "rvConfig_config.svh"

package hostBusPkg;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [`RV_ADDR_BITS-1:0] paddr;
        logic [31:0]              pwdata;
    } apbReqT;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apbRspT;

    // Storage targeted by a host access
    typedef enum logic [1:0] {
        SEL_IMEM,
        SEL_DMEM,
        SEL_REG
    } memSelT;

    typedef struct packed {
        logic        valid;
        logic        write;
        memSelT      sel;
        logic [7:0]  index;  // Word index inside the window
        logic [31:0] wdata;
    } hostAccessT;

endpackage

// File: design/hostBusPort.sv
`timescale 1ns/1ps
`include "rvConfig_config.svh"

module hostBusPort (
    input  logic                   clk,
    input  logic                   reset,
    input  hostBusPkg::apbReqT     apbReq,
    output hostBusPkg::apbRspT     apbRsp,
    output hostBusPkg::hostAccessT hostAccess,
    input  logic [31:0]            hostRdata,
    output logic                   runEnable,
    input  logic                   retire,
    input  logic                   haltEvent,
    input  logic                   illegalEvent
);

    typedef enum logic [1:0] {
        IDLE,
        RUNNING,
        HALTED
    } runStateT;

    localparam logic [`RV_ADDR_BITS-1:0] IMEM_END =
        `RV_ADDR_BITS'(`RV_IMEM_BASE + `RV_IMEM_WORDS * 4);
    localparam logic [`RV_ADDR_BITS-1:0] DMEM_END =
        `RV_ADDR_BITS'(`RV_DMEM_BASE + `RV_DMEM_WORDS * 4);
    localparam logic [`RV_ADDR_BITS-1:0] REG_END =
        `RV_ADDR_BITS'(`RV_REG_BASE + `RV_REG_COUNT * 4);

    runStateT    state;
    logic [31:0] instrCount;
    logic        illegalFlag;   // Sticky until next start
    logic        readPending;   // Wait state of a storage read
    logic        running;
    logic        access;
    logic        aligned;
    logic        inCtrl;
    logic        inStatus;
    logic        inCount;
    logic        inImem;
    logic        inDmem;
    logic        inReg;
    logic        inStorage;
    logic        mapped;
    logic        storageRead;
    logic        startWrite;
    logic        busyError;
    logic [31:0] regRdata;

    assign running   = (state == RUNNING);
    assign runEnable = running;

    assign access  = apbReq.psel && apbReq.penable;
    assign aligned = (apbReq.paddr[1:0] == 2'b00);

    assign inCtrl    = (apbReq.paddr == `RV_CTRL_ADDR);
    assign inStatus  = (apbReq.paddr == `RV_STATUS_ADDR);
    assign inCount   = (apbReq.paddr == `RV_COUNT_ADDR);
    assign inImem    = aligned && apbReq.paddr >= `RV_IMEM_BASE && apbReq.paddr < IMEM_END;
    assign inDmem    = aligned && apbReq.paddr >= `RV_DMEM_BASE && apbReq.paddr < DMEM_END;
    assign inReg     = aligned && apbReq.paddr >= `RV_REG_BASE && apbReq.paddr < REG_END;
    assign inStorage = inImem || inDmem || inReg;
    assign mapped    = inStorage || inCtrl || inStatus || inCount;

    assign storageRead = inStorage && !apbReq.pwrite;
    assign startWrite  = access && apbReq.pwrite && inCtrl && apbReq.pwdata[0];
    // Storage writes and restarts are refused while the program runs
    assign busyError   = running && access && apbReq.pwrite
                         && (inStorage || (inCtrl && apbReq.pwdata[0]));

    always_comb begin
        hostAccess.valid = access && inStorage && !readPending && !busyError;
        hostAccess.write = apbReq.pwrite;
        if (inImem) begin
            hostAccess.sel = hostBusPkg::SEL_IMEM;
        end else if (inDmem) begin
            hostAccess.sel = hostBusPkg::SEL_DMEM;
        end else begin
            hostAccess.sel = hostBusPkg::SEL_REG;
        end
        hostAccess.index = apbReq.paddr[9:2];  // Windows are 1 KB aligned
        hostAccess.wdata = apbReq.pwdata;
    end

    always_comb begin
        regRdata = '0;
        if (inCtrl) begin
            regRdata = {31'b0, running};
        end else if (inStatus) begin
            regRdata = {29'b0, illegalFlag, state == HALTED, running};
        end else if (inCount) begin
            regRdata = instrCount;
        end
    end

    always_comb begin
        apbRsp.pready  = access && (!storageRead || readPending);  // One wait state on reads
        apbRsp.prdata  = storageRead ? hostRdata : regRdata;
        apbRsp.pslverr = apbRsp.pready && (!mapped || busyError);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            instrCount  <= '0;
            illegalFlag <= 1'b0;
            readPending <= 1'b0;
        end else begin
            readPending <= access && storageRead && !readPending;
            if (running) begin
                if (retire) begin
                    instrCount <= instrCount + 32'd1;
                end
                if (haltEvent) begin
                    state <= HALTED;
                end
                if (illegalEvent) begin
                    illegalFlag <= 1'b1;
                end
            end else if (startWrite) begin
                state       <= RUNNING;  // Core restarts from address 0
                instrCount  <= '0;
                illegalFlag <= 1'b0;
            end
        end
    end

    apbSetupFirst: assert property (@(posedge clk) disable iff (reset)
        apbReq.penable |-> $past(apbReq.psel));

endmodule

// File: design/rvConfig_config.svh
`ifndef RVCONFIG_CONFIG_SVH
`define RVCONFIG_CONFIG_SVH

// Storage depths in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256
`define RV_REG_COUNT 32

// APB address width in bits
`define RV_ADDR_BITS 12

// Control and status registers
`define RV_CTRL_ADDR 12'h000
`define RV_STATUS_ADDR 12'h004
`define RV_COUNT_ADDR 12'h008

// Word-addressed storage windows, 4 bytes per entry
`define RV_IMEM_BASE 12'h400
`define RV_DMEM_BASE 12'h800
`define RV_REG_BASE 12'hC00

`endif

// File: design/rvIsaPkg.sv
package rvIsaPkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        R_TYPE = 7'b0110011,
        I_ALU  = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111
    } aluOpT;

    // Write-back source
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_IMM,
        RES_PC4
    } resultSelT;

    typedef struct packed {
        logic      aluSrc;      // Immediate as ALU operand B
        logic      memToReg;    // Load data to rd
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
        logic      branch;      // beq
        logic      jump;        // jal
        logic      pcRelative;  // PC as ALU operand A
        aluOpT     aluOp;
        resultSelT resultSel;
        logic      halt;        // Stop the core after this word
        logic      illegal;
    } ctrlT;

endpackage

// File: design/rvSubsystemTop.sv
`timescale 1ns/1ps

module rvSubsystemTop (
    input  logic               clk,
    input  logic               reset,
    input  hostBusPkg::apbReqT apbReq,
    output hostBusPkg::apbRspT apbRsp
);

    hostBusPkg::hostAccessT hostAccess;
    logic [31:0]            hostRdata;
    logic                   runEnable;
    logic                   retire;
    logic                   haltEvent;
    logic                   illegalEvent;

    hostBusPort hostBusPort_i (
        .clk         (clk),
        .reset       (reset),
        .apbReq      (apbReq),
        .apbRsp      (apbRsp),
        .hostAccess  (hostAccess),
        .hostRdata   (hostRdata),
        .runEnable   (runEnable),
        .retire      (retire),
        .haltEvent   (haltEvent),
        .illegalEvent(illegalEvent)
    );

    executeCore executeCore_i (
        .clk         (clk),
        .reset       (reset),
        .runEnable   (runEnable),
        .hostAccess  (hostAccess),
        .hostRdata   (hostRdata),
        .retire      (retire),
        .haltEvent   (haltEvent),
        .illegalEvent(illegalEvent)
    );

endmodule

// File: list.f
+incdir+design
design/rvIsaPkg.sv
design/hostBusPkg.sv
design/hostBusPort.sv
design/controlUnit.sv
design/executeCore.sv
design/rvSubsystemTop.sv
verification/clockGen.sv
verification/rvSubsystemTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module rvSubsystemTb -o rvSim
./obj_dir/rvSim > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;  // 40 ns period

endmodule

// File: verification/rvSubsystemTb.sv
`timescale 1ns/1ps
`include "rvConfig_config.svh"

module rvSubsystemTb;

    localparam int cycleLimit = 3000;  // About five times the summed length of all tests
    localparam int maxWait    = 4;     // Cycles allowed for pready
    localparam int maxPolls   = 200;

    // Base opcodes of the RV32I encoding
    localparam int opReg    = 'h33;
    localparam int opImm    = 'h13;
    localparam int opLoad   = 'h03;
    localparam int opStore  = 'h23;
    localparam int opBranch = 'h63;
    localparam int opLui    = 'h37;
    localparam int opAuipc  = 'h17;
    localparam int opJal    = 'h6F;
    localparam logic [31:0] ecallWord = 32'h0000_0073;

    logic               clk;
    logic               reset;
    hostBusPkg::apbReqT apbReq;
    hostBusPkg::apbRspT apbRsp;

    int          errCount;
    int          testMark;
    int          testsRun;
    int          failedTests;
    int          cycles;
    int          seed;
    logic [31:0] image[$];  // Program words, index 0 first

    clockGen clockGen_i (
        .clk(clk)
    );

    rvSubsystemTop dut_i (
        .clk   (clk),
        .reset (reset),
        .apbReq(apbReq),
        .apbRsp(apbRsp)
    );

    function automatic logic [31:0] iType(int op, int rd, int rs1, int f3, int imm);
        logic [31:0] o, d, s, f, i;
        o = op;
        d = rd;
        s = rs1;
        f = f3;
        i = imm;
        return {i[11:0], s[4:0], f[2:0], d[4:0], o[6:0]};
    endfunction

    function automatic logic [31:0] rType(int f7, int rs2, int rs1, int f3, int rd);
        logic [31:0] o, h, t, s, f, d;
        o = opReg;
        h = f7;
        t = rs2;
        s = rs1;
        f = f3;
        d = rd;
        return {h[6:0], t[4:0], s[4:0], f[2:0], d[4:0], o[6:0]};
    endfunction

    function automatic logic [31:0] sType(int rs2, int rs1, int imm);  // sw
        logic [31:0] o, t, s, i;
        o = opStore;
        t = rs2;
        s = rs1;
        i = imm;
        return {i[11:5], t[4:0], s[4:0], 3'b010, i[4:0], o[6:0]};
    endfunction

    function automatic logic [31:0] bType(int rs1, int rs2, int imm);  // beq
        logic [31:0] o, s, t, b;
        o = opBranch;
        s = rs1;
        t = rs2;
        b = imm;
        return {b[12], b[10:5], t[4:0], s[4:0], 3'b000, b[4:1], b[11], o[6:0]};
    endfunction

    function automatic logic [31:0] uType(int op, int rd, int imm20);
        logic [31:0] o, d, u;
        o = op;
        d = rd;
        u = imm20;
        return {u[19:0], d[4:0], o[6:0]};
    endfunction

    function automatic logic [31:0] jType(int rd, int imm);
        logic [31:0] o, d, j;
        o = opJal;
        d = rd;
        j = imm;
        return {j[20], j[10:1], j[11], j[19:12], d[4:0], o[6:0]};
    endfunction

    function automatic logic [`RV_ADDR_BITS-1:0] wordAddr(int base, int idx);
        return `RV_ADDR_BITS'(base + 4 * idx);
    endfunction

    task automatic compareWord(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s read %h, expected %h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic compareStatus(input string what, input logic [2:0] got,
                                 input logic [2:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s bits %b, expected %b", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic compareErr(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s pslverr %b, expected %b", $time, what, got, exp);
            errCount++;
        end
    endtask

    // Setup and access phases, each driven on a falling edge
    task automatic apbTransfer(input logic write, input logic [`RV_ADDR_BITS-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        int waits;
        @(negedge clk);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(negedge clk);
        apbReq.penable = 1'b1;
        waits = 0;
        #1;
        while (!apbRsp.pready && waits < maxWait) begin
            @(negedge clk);
            #1;
            waits++;
        end
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        if (!apbRsp.pready) begin
            $display("APB access to address %h got no pready within %0d cycles", addr, maxWait);
            errCount++;
        end
        @(negedge clk);  // Transfer ended on the rising edge just passed
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [`RV_ADDR_BITS-1:0] addr, input logic [31:0] data,
                            output logic err);
        logic [31:0] ignored;
        apbTransfer(1'b1, addr, data, ignored, err);
    endtask

    task automatic apbRead(input logic [`RV_ADDR_BITS-1:0] addr, output logic [31:0] data,
                           output logic err);
        apbTransfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic writeChecked(input logic [`RV_ADDR_BITS-1:0] addr, input logic [31:0] data);
        logic err;
        apbWrite(addr, data, err);
        compareErr($sformatf("write to %h", addr), err, 1'b0);
    endtask

    task automatic readChecked(input string what, input logic [`RV_ADDR_BITS-1:0] addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apbRead(addr, data, err);
        compareErr(what, err, 1'b0);
        compareWord(what, data, exp);
    endtask

    task automatic checkReg(input int r, input logic [31:0] exp);
        readChecked($sformatf("x%0d", r), wordAddr(`RV_REG_BASE, r), exp);
    endtask

    task automatic runImage();
        foreach (image[i]) begin
            writeChecked(wordAddr(`RV_IMEM_BASE, i), image[i]);
        end
        writeChecked(`RV_CTRL_ADDR, 32'd1);
    endtask

    task automatic waitHalt();
        logic [31:0] status;
        logic        err;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < maxPolls) begin
            apbRead(`RV_STATUS_ADDR, status, err);
            polls++;
        end
        if (!status[1]) begin
            $display("Core did not halt within %0d status polls", maxPolls);
            errCount++;
        end
    endtask

    task automatic checkHalt(input logic [2:0] expStatus, input int expCount);
        logic [31:0] data;
        logic        err;
        apbRead(`RV_STATUS_ADDR, data, err);
        compareErr("STATUS", err, 1'b0);
        compareStatus("STATUS", data[2:0], expStatus);
        readChecked("COUNT", `RV_COUNT_ADDR, expCount);
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errCount == testMark) begin
            $display("Test %0d, %s: passed", testsRun, name);
        end else begin
            failedTests++;
            $display("Test %0d, %s: failed with %0d mismatches", testsRun, name,
                     errCount - testMark);
        end
        testMark = errCount;
    endtask

    task automatic testResetAndBus();
        logic [31:0] data;
        logic        err;
        readChecked("STATUS after reset", `RV_STATUS_ADDR, 32'd0);
        readChecked("COUNT after reset", `RV_COUNT_ADDR, 32'd0);
        apbRead(12'h010, data, err);
        compareErr("unmapped read", err, 1'b1);
        compareWord("unmapped read", data, 32'd0);
        // Countdown of 40 passes keeps the core busy for 120 cycles
        image.delete();
        image.push_back(iType(opImm, 1, 0, 0, 40));
        image.push_back(iType(opImm, 1, 1, 0, -1));
        image.push_back(bType(1, 0, 8));
        image.push_back(jType(0, -8));
        image.push_back(ecallWord);
        runImage();
        apbWrite(wordAddr(`RV_IMEM_BASE, 0), 32'hDEAD_BEEF, err);
        compareErr("imem write while running", err, 1'b1);
        apbRead(`RV_STATUS_ADDR, data, err);
        compareStatus("STATUS while running", data[2:0], 3'b001);
        waitHalt();
        readChecked("imem word 0", wordAddr(`RV_IMEM_BASE, 0), image[0]);
        checkReg(1, 32'd0);
        endTest("reset state and bus rules");
    endtask

    task automatic testArith();
        logic [31:0] opA [3];
        logic [31:0] opB [3];
        logic [31:0] raw;
        int          base;
        image.delete();
        for (int p = 0; p < 3; p++) begin
            raw    = $random(seed);
            opA[p] = {{20{raw[11]}}, raw[11:0]};  // addi takes 12 signed bits
            raw    = $random(seed);
            opB[p] = {{20{raw[11]}}, raw[11:0]};
            base   = 1 + 7 * p;
            image.push_back(iType(opImm, base, 0, 0, opA[p]));
            image.push_back(iType(opImm, base + 1, 0, 0, opB[p]));
            image.push_back(rType('h00, base + 1, base, 0, base + 2));  // add
            image.push_back(rType('h20, base + 1, base, 0, base + 3));  // sub
            image.push_back(rType('h00, base + 1, base, 7, base + 4));  // and
            image.push_back(rType('h00, base + 1, base, 6, base + 5));  // or
            image.push_back(rType('h00, base + 1, base, 2, base + 6));  // slt
        end
        image.push_back(ecallWord);
        runImage();
        waitHalt();
        checkHalt(3'b010, 21);
        for (int p = 0; p < 3; p++) begin
            base = 1 + 7 * p;
            checkReg(base, opA[p]);
            checkReg(base + 1, opB[p]);
            checkReg(base + 2, opA[p] + opB[p]);
            checkReg(base + 3, opA[p] - opB[p]);
            checkReg(base + 4, opA[p] & opB[p]);
            checkReg(base + 5, opA[p] | opB[p]);
            checkReg(base + 6, ($signed(opA[p]) < $signed(opB[p])) ? 32'd1 : 32'd0);
        end
        endTest("R-type and addi");
    endtask

    task automatic testLoadStore();
        image.delete();
        image.push_back(iType(opImm, 10, 0, 0, 'h123));
        image.push_back(iType(opImm, 11, 0, 0, -5));
        image.push_back(uType(opLui, 12, 'hABCDE));
        image.push_back(iType(opImm, 13, 0, 0, 16));  // Byte address of word 4
        image.push_back(sType(10, 13, 0));
        image.push_back(sType(11, 13, 4));
        image.push_back(sType(12, 13, 8));
        image.push_back(iType(opLoad, 14, 13, 2, 0));
        image.push_back(iType(opLoad, 15, 13, 2, 4));
        image.push_back(iType(opLoad, 16, 13, 2, 8));
        image.push_back(ecallWord);
        runImage();
        waitHalt();
        checkHalt(3'b010, 10);
        readChecked("dmem word 3", wordAddr(`RV_DMEM_BASE, 3), 32'd0);
        readChecked("dmem word 4", wordAddr(`RV_DMEM_BASE, 4), 32'h0000_0123);
        readChecked("dmem word 5", wordAddr(`RV_DMEM_BASE, 5), 32'hFFFF_FFFB);
        readChecked("dmem word 6", wordAddr(`RV_DMEM_BASE, 6), 32'hABCD_E000);
        checkReg(14, 32'h0000_0123);
        checkReg(15, 32'hFFFF_FFFB);
        checkReg(16, 32'hABCD_E000);
        endTest("loads and stores");
    endtask

    task automatic testBranchJump();
        int n;
        int expCount;
        n = 5;
        writeChecked(wordAddr(`RV_REG_BASE, 6), 32'h5A5A_5A5A);
        image.delete();
        image.push_back(iType(opImm, 1, 0, 0, n));
        image.push_back(iType(opImm, 2, 0, 0, 0));
        image.push_back(iType(opImm, 2, 2, 0, 3));   // 8: loop body
        image.push_back(iType(opImm, 1, 1, 0, -1));
        image.push_back(bType(1, 0, 8));             // 16: exit to 24
        image.push_back(jType(0, -12));
        image.push_back(jType(5, 8));                // 24: skip word 28
        image.push_back(iType(opImm, 6, 0, 0, 99));
        image.push_back(ecallWord);
        runImage();
        waitHalt();
        // Two setup words, three per pass, a back jump on all but the last pass, then the skip
        expCount = 2 + 3 * n + (n - 1) + 1;
        checkHalt(3'b010, expCount);
        checkReg(1, 32'd0);
        checkReg(2, 3 * n);
        checkReg(5, 32'd28);
        checkReg(6, 32'h5A5A_5A5A);
        endTest("branch and jump");
    endtask

    task automatic testUpper();
        image.delete();
        image.push_back(uType(opLui, 20, 'h12345));
        image.push_back(uType(opAuipc, 21, 'h00010));
        image.push_back(uType(opAuipc, 22, 'hFFFFF));
        image.push_back(ecallWord);
        runImage();
        waitHalt();
        checkHalt(3'b010, 3);
        checkReg(20, 32'h1234_5000);
        checkReg(21, 32'd4 + 32'h0001_0000);
        checkReg(22, 32'd8 + 32'hFFFF_F000);
        endTest("lui and auipc");
    endtask

    task automatic testIllegal();
        int badIndex;
        badIndex = 2;
        image.delete();
        image.push_back(iType(opImm, 23, 0, 0, 7));
        image.push_back(iType(opImm, 23, 23, 0, 1));
        image.push_back(32'h0000_007F);  // Opcode outside the subset
        image.push_back(iType(opImm, 24, 0, 0, 55));
        image.push_back(iType(opImm, 25, 0, 0, 66));
        image.push_back(ecallWord);
        runImage();
        waitHalt();
        checkHalt(3'b110, badIndex);
        checkReg(23, 32'd8);
        checkReg(24, 32'd0);
        checkReg(25, 32'd0);
        endTest("illegal instruction");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        errCount    = 0;
        testMark    = 0;
        testsRun    = 0;
        failedTests = 0;
        cycles      = 0;
        seed        = 85;
        apbReq      = '0;
        reset       = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        testResetAndBus();
        testArith();
        testLoadStore();
        testBranchJump();
        testUpper();
        testIllegal();

        $display("Tests run %0d, tests failed %0d, mismatches %0d", testsRun, failedTests,
                 errCount);
        if (errCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
